// ==== hw/arch_pkg.sv ====
package arch_pkg;

    localparam int reg_num = 32;
    localparam int reg_addr_len = 5;

    typedef logic [reg_addr_len-1:0] reg_addr_t;

    // only alu and load write a destination
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_load   = 3'd1,
        op_store  = 3'd2,
        op_branch = 3'd3,
        op_nop    = 3'd4
    } opcode_e;

    // decoded instruction as it leaves decode
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t dest;
        reg_addr_t src1;
        reg_addr_t src2;
    } arch_instr_t;

endpackage

// ==== hw/rename_pkg.sv ====
package rename_pkg;

    localparam int rob_size = 16;
    localparam int rob_tag_len = 4;

    typedef logic [rob_tag_len-1:0] rob_tag_t;

    // all ones marks an entry that is not renamed
    localparam rob_tag_t no_tag = {rob_tag_len{1'b1}};

    typedef struct packed {
        rob_tag_t rob_tag;
        logic     ready_in_rob;
    } map_entry_t;

    typedef enum logic [1:0] {
        stat_arch    = 2'b00, // value in register file
        stat_pending = 2'b10, // waiting on rob tag
        stat_ready   = 2'b11  // value sits in rob
    } data_stat_e;

    typedef struct packed {
        data_stat_e         data_stat;
        arch_pkg::reg_addr_t reg_addr;
        rob_tag_t           rob_tag;
    } src_info_t;

    typedef struct packed {
        src_info_t           src1;
        src_info_t           src2;
        arch_pkg::reg_addr_t dest;
        rob_tag_t            rob_tag;
        logic                writes_dest;
    } renamed_t;

    // shared by cdb and retire
    typedef struct packed {
        arch_pkg::reg_addr_t reg_addr;
        rob_tag_t            rob_tag;
    } tag_msg_t;

endpackage

// ==== hw/map_table.sv ====
`timescale 1ns/1ps

module map_table (
    input  logic                   clk,
    input  logic                   reset,
    input  arch_pkg::arch_instr_t  instr,
    input  logic                   assign_en,
    input  rename_pkg::rob_tag_t   assign_tag,
    input  logic                   cdb_valid,
    input  rename_pkg::tag_msg_t   cdb,
    input  logic                   retire_valid,
    input  rename_pkg::tag_msg_t   retire,
    input  logic                   clear_en,
    input  arch_pkg::reg_addr_t    clear_addr,
    output rename_pkg::renamed_t   renamed
);

    rename_pkg::map_entry_t table_q [arch_pkg::reg_num];
    rename_pkg::map_entry_t table_next [arch_pkg::reg_num];

    // classify one source against the current table
    function automatic rename_pkg::src_info_t lookup(input arch_pkg::reg_addr_t addr);
        rename_pkg::src_info_t info;
        rename_pkg::map_entry_t entry;
        entry = table_q[addr];
        info.reg_addr = addr;
        info.rob_tag = entry.rob_tag;
        if (entry.rob_tag == rename_pkg::no_tag) begin
            info.data_stat = rename_pkg::stat_arch;
        end else if (entry.ready_in_rob) begin
            info.data_stat = rename_pkg::stat_ready;
        end else begin
            info.data_stat = rename_pkg::stat_pending;
        end
        return info;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < arch_pkg::reg_num; i++) begin
                table_q[i].rob_tag <= rename_pkg::no_tag;
                table_q[i].ready_in_rob <= 1'b0;
            end
        end else begin
            table_q <= table_next;
        end
    end

    // later updates override earlier ones
    always_comb begin
        table_next = table_q;

        if (retire_valid) begin
            if (table_q[retire.reg_addr].rob_tag == retire.rob_tag) begin
                table_next[retire.reg_addr].rob_tag = rename_pkg::no_tag;
                table_next[retire.reg_addr].ready_in_rob = 1'b0;
            end
        end

        if (cdb_valid) begin
            if (table_q[cdb.reg_addr].rob_tag == cdb.rob_tag) begin
                table_next[cdb.reg_addr].ready_in_rob = 1'b1; // result broadcast
            end
        end

        if (assign_en) begin
            table_next[instr.dest].rob_tag = assign_tag;
            table_next[instr.dest].ready_in_rob = 1'b0;
        end

        if (clear_en) begin
            table_next[clear_addr].rob_tag = rename_pkg::no_tag; // flush walk
            table_next[clear_addr].ready_in_rob = 1'b0;
        end
    end

    always_comb begin
        renamed.src1 = lookup(instr.src1);
        renamed.src2 = lookup(instr.src2);
        renamed.dest = instr.dest;
        renamed.rob_tag = assign_tag;
        renamed.writes_dest = assign_en;
    end

endmodule

// ==== hw/rob_tag_ring.sv ====
`timescale 1ns/1ps

module rob_tag_ring (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc,
    input  logic                 free,
    input  logic                 ring_clear,
    output rename_pkg::rob_tag_t next_tag,
    output logic                 full
);

    // no_tag is reserved, so one tag fewer than the rob holds
    localparam int usable_tags = rename_pkg::rob_size - 1;
    localparam rename_pkg::rob_tag_t last_tag = rename_pkg::rob_tag_t'(usable_tags - 1);
    localparam rename_pkg::rob_tag_t count_max = rename_pkg::rob_tag_t'(usable_tags);

    rename_pkg::rob_tag_t tail;  // next tag to hand out
    rename_pkg::rob_tag_t count;

    function automatic rename_pkg::rob_tag_t step(input rename_pkg::rob_tag_t ptr);
        if (ptr == last_tag) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || ring_clear) begin
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= step(tail);
            end
            if (alloc && !free) begin
                count <= count + 1'b1;
            end else if (free && !alloc) begin
                count <= count - 1'b1;
            end
        end
    end

    assign next_tag = tail;
    assign full = (count == count_max);

endmodule

// ==== hw/rename_ctrl.sv ====
`timescale 1ns/1ps

module rename_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  disp_valid,
    input  arch_pkg::arch_instr_t disp_instr,
    input  logic                  full,
    output logic                  disp_ready,
    output logic                  alloc,
    output logic                  assign_en,
    output logic                  clear_en,
    output arch_pkg::reg_addr_t   clear_addr,
    output logic                  ring_clear
);

    typedef enum logic {
        st_run,
        st_flush
    } state_e;

    localparam arch_pkg::reg_addr_t last_reg = arch_pkg::reg_addr_t'(arch_pkg::reg_num - 1);

    state_e              state;
    arch_pkg::reg_addr_t walk_idx;
    logic                writes_dest;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_run;
            walk_idx <= '0;
        end else if (flush) begin
            state <= st_flush; // restart walk from r0
            walk_idx <= '0;
        end else if (state == st_flush) begin
            walk_idx <= walk_idx + 1'b1;
            if (walk_idx == last_reg) begin
                state <= st_run;
            end
        end
    end

    always_comb begin
        case (disp_instr.opcode)
            arch_pkg::op_alu,
            arch_pkg::op_load: writes_dest = 1'b1;
            default:           writes_dest = 1'b0;
        endcase
    end

    assign disp_ready = (state == st_run) && !full;
    assign alloc = disp_valid && disp_ready;       // store and branch take a tag too
    assign assign_en = alloc && writes_dest;

    assign clear_en = (state == st_flush);
    assign clear_addr = walk_idx;
    assign ring_clear = flush; // ring empties on the flush edge

endmodule

// ==== hw/rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  disp_valid,
    input  arch_pkg::arch_instr_t disp_instr,
    output logic                  disp_ready,
    output logic                  renamed_valid,
    output rename_pkg::renamed_t  renamed,
    input  logic                  cdb_valid,
    input  rename_pkg::tag_msg_t  cdb,
    input  logic                  retire_valid,
    input  rename_pkg::tag_msg_t  retire
);

    rename_pkg::rob_tag_t next_tag;
    logic                 full;
    logic                 alloc;
    logic                 assign_en;
    logic                 clear_en;
    arch_pkg::reg_addr_t  clear_addr;
    logic                 ring_clear;
    logic                 upd_en;
    logic                 cdb_en;
    logic                 retire_en;

    // ready low without full means the flush walk is running
    assign upd_en = disp_ready || full;
    assign cdb_en = cdb_valid && upd_en;
    assign retire_en = retire_valid && upd_en;
    assign renamed_valid = alloc;

    rename_ctrl ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_instr (disp_instr),
        .full       (full),
        .disp_ready (disp_ready),
        .alloc      (alloc),
        .assign_en  (assign_en),
        .clear_en   (clear_en),
        .clear_addr (clear_addr),
        .ring_clear (ring_clear)
    );

    rob_tag_ring ring_i (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .free       (retire_en),
        .ring_clear (ring_clear),
        .next_tag   (next_tag),
        .full       (full)
    );

    map_table map_i (
        .clk          (clk),
        .reset        (reset),
        .instr        (disp_instr),
        .assign_en    (assign_en),
        .assign_tag   (next_tag),
        .cdb_valid    (cdb_en),
        .cdb          (cdb),
        .retire_valid (retire_en),
        .retire       (retire),
        .clear_en     (clear_en),
        .clear_addr   (clear_addr),
        .renamed      (renamed)
    );

endmodule

// ==== test/tb_rename_stage.sv ====
`timescale 1ns/1ps

module tb_rename_stage;

    localparam int max_cycles = 2000; // run needs a few hundred cycles

    logic clk, reset, flush, disp_valid, disp_ready, renamed_valid, cdb_valid, retire_valid;
    arch_pkg::arch_instr_t  disp_instr;
    rename_pkg::renamed_t   renamed;
    rename_pkg::tag_msg_t   cdb, retire;

    rename_pkg::map_entry_t model_map [arch_pkg::reg_num];
    rename_pkg::rob_tag_t   model_tail;
    int model_count, flush_left;
    int errors = 0, mark = 0, pass_count = 0, fail_count = 0, cycles = 0;
    logic [31:0] lfsr_state = 32'd86916;
    rename_pkg::tag_msg_t live_q [$]; // tags in flight, oldest first

    rename_stage dut_i (
        .clk(clk), .reset(reset), .flush(flush),
        .disp_valid(disp_valid), .disp_instr(disp_instr), .disp_ready(disp_ready),
        .renamed_valid(renamed_valid), .renamed(renamed),
        .cdb_valid(cdb_valid), .cdb(cdb), .retire_valid(retire_valid), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic int unsigned rand_bits(input int n);
        int unsigned val;
        logic fb;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = (val << 1) | lfsr_state[0];
        end
        return val;
    endfunction

    function automatic arch_pkg::arch_instr_t mk_instr(input arch_pkg::opcode_e op,
                                                       input int dest, input int s1, input int s2);
        arch_pkg::arch_instr_t instr;
        instr.opcode = op;
        instr.dest = arch_pkg::reg_addr_t'(dest);
        instr.src1 = arch_pkg::reg_addr_t'(s1);
        instr.src2 = arch_pkg::reg_addr_t'(s2);
        return instr;
    endfunction

    function automatic arch_pkg::arch_instr_t rand_instr();
        arch_pkg::opcode_e op;
        op = arch_pkg::opcode_e'(rand_bits(2)); // alu, load, store or branch
        return mk_instr(op, rand_bits(5), rand_bits(5), rand_bits(5));
    endfunction

    function automatic logic writes(input arch_pkg::opcode_e op);
        return (op == arch_pkg::op_alu) || (op == arch_pkg::op_load);
    endfunction

    function automatic rename_pkg::src_info_t ref_src(input arch_pkg::reg_addr_t addr);
        rename_pkg::src_info_t info;
        info.reg_addr = addr;
        info.rob_tag = model_map[addr].rob_tag;
        if (model_map[addr].rob_tag == rename_pkg::no_tag) begin
            info.data_stat = rename_pkg::stat_arch;
        end else if (model_map[addr].ready_in_rob) begin
            info.data_stat = rename_pkg::stat_ready;
        end else begin
            info.data_stat = rename_pkg::stat_pending;
        end
        return info;
    endfunction

    // expected output from the model table
    function automatic rename_pkg::renamed_t ref_renamed(input arch_pkg::arch_instr_t instr,
                                                         input logic fire);
        rename_pkg::renamed_t r;
        r.src1 = ref_src(instr.src1);
        r.src2 = ref_src(instr.src2);
        r.dest = instr.dest;
        r.rob_tag = model_tail;
        r.writes_dest = fire && writes(instr.opcode);
        return r;
    endfunction

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic update_model(input logic fire);
        rename_pkg::map_entry_t old_map [arch_pkg::reg_num];
        logic upd;
        logic free;
        old_map = model_map;
        upd = (flush_left == 0); // cdb and retire dropped during the walk
        free = retire_valid && upd;
        if (free && old_map[retire.reg_addr].rob_tag == retire.rob_tag) begin
            model_map[retire.reg_addr].rob_tag = rename_pkg::no_tag;
            model_map[retire.reg_addr].ready_in_rob = 1'b0;
        end
        if (cdb_valid && upd && old_map[cdb.reg_addr].rob_tag == cdb.rob_tag) begin
            model_map[cdb.reg_addr].ready_in_rob = 1'b1;
        end
        if (fire && writes(disp_instr.opcode)) begin
            model_map[disp_instr.dest].rob_tag = model_tail;
            model_map[disp_instr.dest].ready_in_rob = 1'b0;
        end
        if (flush_left > 0) begin
            model_map[arch_pkg::reg_num - flush_left].rob_tag = rename_pkg::no_tag;
            model_map[arch_pkg::reg_num - flush_left].ready_in_rob = 1'b0;
        end
        if (flush) begin
            model_tail = '0;
            model_count = 0;
            flush_left = arch_pkg::reg_num;
        end else begin
            if (fire) begin
                model_tail = (model_tail == 4'd14) ? 4'd0 : model_tail + 1'b1;
            end
            model_count = model_count + int'(fire) - int'(free);
            if (flush_left > 0) begin
                flush_left--;
            end
        end
    endtask

    // compare mid cycle and then advance the model
    always @(negedge clk) begin : compare
        rename_pkg::renamed_t exp;
        logic exp_ready;
        logic fire;
        if (reset) begin
            for (int i = 0; i < arch_pkg::reg_num; i++) begin
                model_map[i].rob_tag = rename_pkg::no_tag;
                model_map[i].ready_in_rob = 1'b0;
            end
            model_tail = '0;
            model_count = 0;
            flush_left = 0;
        end else begin
            exp_ready = (flush_left == 0) && (model_count != rename_pkg::rob_size - 1);
            fire = disp_valid && exp_ready;
            exp = ref_renamed(disp_instr, fire);
            check("disp_ready", exp_ready, disp_ready);
            check("renamed_valid", fire, renamed_valid);
            check("renamed.src1", exp.src1, renamed.src1);
            check("renamed.src2", exp.src2, renamed.src2);
            check("renamed.dest", exp.dest, renamed.dest);
            check("renamed.rob_tag", exp.rob_tag, renamed.rob_tag);
            check("renamed.writes_dest", exp.writes_dest, renamed.writes_dest);
            update_model(fire);
        end
    end

    task automatic drive(input logic dv, input arch_pkg::arch_instr_t instr,
                         input logic cv, input rename_pkg::tag_msg_t cmsg,
                         input logic rv, input rename_pkg::tag_msg_t rmsg, input logic fl);
        @(posedge clk);
        #1;
        disp_valid = dv;
        disp_instr = instr;
        cdb_valid = cv;
        cdb = cmsg;
        retire_valid = rv;
        retire = rmsg;
        flush = fl;
    endtask

    task automatic dispatch(input arch_pkg::arch_instr_t instr, output rename_pkg::rob_tag_t tag);
        rename_pkg::tag_msg_t msg;
        drive(1'b1, instr, 1'b0, '0, 1'b0, '0, 1'b0);
        while (disp_ready !== 1'b1) begin
            drive(1'b1, instr, 1'b0, '0, 1'b0, '0, 1'b0);
        end
        tag = renamed.rob_tag; // fires on the coming edge
        msg.reg_addr = instr.dest;
        msg.rob_tag = tag;
        live_q.push_back(msg);
    endtask

    task automatic retire_one();
        drive(1'b0, disp_instr, 1'b0, '0, 1'b1, live_q.pop_front(), 1'b0);
    endtask

    task automatic drain();
        while (live_q.size() > 0) begin
            retire_one();
        end
        drive(1'b0, disp_instr, 1'b0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic expect_stat(input int addr, input rename_pkg::data_stat_e stat,
                               input rename_pkg::rob_tag_t tag);
        drive(1'b0, mk_instr(arch_pkg::op_nop, 0, addr, addr), 1'b0, '0, 1'b0, '0, 1'b0);
        #2;
        check("renamed.src1.data_stat", stat, renamed.src1.data_stat);
        if (stat != rename_pkg::stat_arch) begin
            check("renamed.src1.rob_tag", tag, renamed.src1.rob_tag);
        end
    endtask

    task automatic end_test(input string name);
        drive(1'b0, disp_instr, 1'b0, '0, 1'b0, '0, 1'b0);
        @(negedge clk);
        #1;
        if (errors == mark) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin : stimulus
        rename_pkg::rob_tag_t t, t_a, t_b;
        arch_pkg::arch_instr_t instr;
        rename_pkg::tag_msg_t msg;
        int low_cycles;
        reset = 1'b1;
        flush = 1'b0;
        disp_valid = 1'b0;
        disp_instr = '0;
        cdb_valid = 1'b0;
        cdb = '0;
        retire_valid = 1'b0;
        retire = '0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < 10; i++) begin
            expect_stat(rand_bits(5), rename_pkg::stat_arch, rename_pkg::no_tag);
        end
        end_test("1 reset lookup");

        dispatch(mk_instr(arch_pkg::op_alu, 3, 0, 0), t_a);
        dispatch(mk_instr(arch_pkg::op_load, 4, 0, 0), t_b);
        check("renamed.rob_tag", t_a + 1'b1, t_b);
        expect_stat(3, rename_pkg::stat_pending, t_a);
        dispatch(mk_instr(arch_pkg::op_store, 9, 3, 4), t);
        expect_stat(9, rename_pkg::stat_arch, rename_pkg::no_tag); // store leaves r9 alone
        for (int i = 0; i < 6; i++) begin
            dispatch(rand_instr(), t);
        end
        drain();
        end_test("2 dispatch and allocate");

        dispatch(mk_instr(arch_pkg::op_alu, 5, 1, 2), t_a);
        msg.reg_addr = 5'd5;
        msg.rob_tag = t_a;
        drive(1'b0, disp_instr, 1'b1, msg, 1'b0, '0, 1'b0);
        expect_stat(5, rename_pkg::stat_ready, t_a);
        dispatch(mk_instr(arch_pkg::op_alu, 5, 1, 2), t_b);
        drive(1'b0, disp_instr, 1'b1, msg, 1'b0, '0, 1'b0); // stale tag
        expect_stat(5, rename_pkg::stat_pending, t_b);
        drain();
        end_test("3 cdb ready and stale cdb");

        dispatch(mk_instr(arch_pkg::op_alu, 7, 0, 0), t_a);
        dispatch(mk_instr(arch_pkg::op_alu, 7, 0, 0), t_b);
        retire_one();
        expect_stat(7, rename_pkg::stat_pending, t_b);
        retire_one();
        expect_stat(7, rename_pkg::stat_arch, rename_pkg::no_tag);
        for (int i = 0; i < 13; i++) begin
            dispatch(rand_instr(), t);
        end
        drain();
        dispatch(rand_instr(), t);
        check("renamed.rob_tag after wrap", t_a, t);
        drain();
        end_test("4 retire and tag reuse");

        for (int i = 0; i < rename_pkg::rob_size - 1; i++) begin
            dispatch(rand_instr(), t);
        end
        instr = rand_instr();
        for (int i = 0; i < 3; i++) begin
            drive(1'b1, instr, 1'b0, '0, 1'b0, '0, 1'b0);
            check("disp_ready while full", 1'b0, disp_ready);
        end
        drive(1'b1, instr, 1'b0, '0, 1'b1, live_q.pop_front(), 1'b0);
        drive(1'b0, instr, 1'b0, '0, 1'b0, '0, 1'b0);
        check("disp_ready after retire", 1'b1, disp_ready);
        drain();
        end_test("5 back-pressure");

        for (int i = 0; i < 4; i++) begin
            dispatch(mk_instr(arch_pkg::op_alu, i * 3 + 1, 0, 0), t);
        end
        msg.reg_addr = 5'd1;
        msg.rob_tag = '0;
        drive(1'b0, disp_instr, 1'b0, '0, 1'b0, '0, 1'b1);
        live_q.delete();
        drive(1'b0, disp_instr, 1'b0, '0, 1'b0, '0, 1'b0);
        low_cycles = 0;
        while (disp_ready !== 1'b1) begin
            low_cycles++;
            drive(1'b0, disp_instr, 1'b0, '0, low_cycles == 10, msg, 1'b0); // retire mid walk
        end
        if (low_cycles != arch_pkg::reg_num) begin
            errors++;
            $display("FAILED %0t disp_ready low cycles expected 32 got %0d", $time, low_cycles);
        end
        for (int i = 0; i < arch_pkg::reg_num; i++) begin
            expect_stat(i, rename_pkg::stat_arch, rename_pkg::no_tag);
        end
        dispatch(rand_instr(), t);
        check("renamed.rob_tag after flush", 4'd0, t);
        drain();
        end_test("6 flush");

        $display("tests passed %0d failed %0d, check errors %0d", pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/arch_pkg.sv
hw/rename_pkg.sv
hw/map_table.sv
hw/rob_tag_ring.sv
hw/rename_ctrl.sv
hw/rename_stage.sv
test/tb_rename_stage.sv

// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - hw/arch_pkg.sv
  - hw/rename_pkg.sv
  - hw/map_table.sv
  - hw/rob_tag_ring.sv
  - hw/rename_ctrl.sv
  - hw/rename_stage.sv
  - target: test
    files:
      - test/tb_rename_stage.sv
